//--- list.f
logic/vunit_pkg.sv
logic/vunit_order_queue.sv
logic/vunit_alu.sv
logic/vunit_mul.sv
logic/vunit_mux.sv
test/vunit_mux_props.sv
test/vunit_mux_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the dispatch multiplexer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module vunit_mux_tb \
    -o vunit_mux_sim

./obj_dir/vunit_mux_sim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

//--- test/vunit_mux_tb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the dispatch multiplexer: random traffic
// with back-pressure, reference model, in-order scoreboard and watchdog
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_mux_tb;

    import vunit_pkg::*;

    localparam int unsigned QUEUE_DEPTH  = 4;
    localparam int unsigned MUL_STAGES   = 3;
    localparam int unsigned CLK_PERIOD   = 8;
    localparam int unsigned HALF_PERIOD  = CLK_PERIOD / 2;
    localparam int unsigned NUM_INSTR    = 400;
    localparam int unsigned DIRECTED_CNT = 16;
    localparam int unsigned TIMEOUT_NS   = NUM_INSTR * 20 * CLK_PERIOD;
    localparam logic [31:0] SEED         = 32'h6a56e656;

    logic               clk_i;
    logic               arst_n_i;
    logic               pipe_in_valid_i;
    logic               pipe_in_ready_o;
    pipe_ctrl_t         pipe_in_ctrl_i;
    logic [DATA_W-1:0]  pipe_in_op_a_i;
    logic [DATA_W-1:0]  pipe_in_op_b_i;
    logic               pipe_out_valid_o;
    logic               pipe_out_ready_i;
    pipe_res_t          pipe_out_res_o;

    // Expected results in issue order
    pipe_res_t          sb_q [$];
    int unsigned        out_count;

    vunit_mux #(
        .QUEUE_DEPTH      ( QUEUE_DEPTH      ),
        .MUL_STAGES       ( MUL_STAGES       )
    ) u_vunit_mux (
        .clk_i            ( clk_i            ),
        .arst_n_i         ( arst_n_i         ),
        .pipe_in_valid_i  ( pipe_in_valid_i  ),
        .pipe_in_ready_o  ( pipe_in_ready_o  ),
        .pipe_in_ctrl_i   ( pipe_in_ctrl_i   ),
        .pipe_in_op_a_i   ( pipe_in_op_a_i   ),
        .pipe_in_op_b_i   ( pipe_in_op_b_i   ),
        .pipe_out_valid_o ( pipe_out_valid_o ),
        .pipe_out_ready_i ( pipe_out_ready_i ),
        .pipe_out_res_o   ( pipe_out_res_o   )
    );

    always #(HALF_PERIOD) clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    // Result as defined for each opcode, multiply on the unsigned 64-bit product
    function automatic pipe_res_t expected_result(input pipe_ctrl_t ctrl,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        pipe_res_t            res;
        logic [2*DATA_W-1:0]  prod;
        prod      = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
        res.id    = ctrl.id;
        res.vaddr = ctrl.vaddr;
        case (ctrl.op)
            OP_ADD:  res.data = a + b;
            OP_SUB:  res.data = a - b;
            OP_AND:  res.data = a & b;
            OP_XOR:  res.data = a ^ b;
            OP_MUL:  res.data = prod[DATA_W-1:0];
            OP_MULH: res.data = prod[2*DATA_W-1:DATA_W];
            default: res.data = '0;
        endcase
        return res;
    endfunction

    function automatic op_unit_e pick_unit();
        return ($urandom_range(0, 1) == 0) ? UNIT_ALU : UNIT_MUL;
    endfunction

    // Opcode that matches the chosen unit
    function automatic op_code_e pick_op(input op_unit_e unit);
        if (unit == UNIT_MUL) begin
            return ($urandom_range(0, 1) == 0) ? OP_MUL : OP_MULH;
        end
        case ($urandom_range(0, 3))
            0:       return OP_ADD;
            1:       return OP_SUB;
            2:       return OP_AND;
            default: return OP_XOR;
        endcase
    endfunction

    // Corner values now and then, otherwise uniform
    function automatic logic [DATA_W-1:0] pick_operand();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            default: return $urandom();
        endcase
    endfunction

    always @(posedge clk_i) begin
        pipe_out_ready_i <= ($urandom_range(0, 99) < 70);
    end

    // Input monitor feeds the scoreboard on every accepted instruction
    always @(posedge clk_i) begin
        if (arst_n_i && pipe_in_valid_i && pipe_in_ready_o) begin
            sb_q.push_back(expected_result(pipe_in_ctrl_i, pipe_in_op_a_i, pipe_in_op_b_i));
        end
    end

    always @(posedge clk_i) begin
        pipe_res_t exp_res;
        if (arst_n_i && pipe_out_valid_o && pipe_out_ready_i) begin
            assert (sb_q.size() != 0)
                else report_failure("Output transfer seen with no instruction outstanding");
            exp_res = sb_q.pop_front();
            assert (pipe_out_res_o === exp_res)
                else report_failure($sformatf("MISMATCH pipe_out_res_o expected %h actual %h",
                                              exp_res, pipe_out_res_o));
            out_count++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        report_failure($sformatf("Timeout: run did not complete within %0d ns", TIMEOUT_NS));
    end

    initial begin : stimulus
        pipe_ctrl_t   ctrl;
        op_unit_e     unit;
        int unsigned  gap;
        void'($urandom(SEED));
        clk_i            = 1'b0;
        arst_n_i         = 1'b0;
        pipe_in_valid_i  = 1'b0;
        pipe_in_ctrl_i   = '0;
        pipe_in_op_a_i   = '0;
        pipe_in_op_b_i   = '0;
        pipe_out_ready_i = 1'b0;
        out_count        = 0;
        repeat (2) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(posedge clk_i);
        assert (pipe_out_valid_o == 1'b0)
            else report_failure($sformatf("MISMATCH pipe_out_valid_o expected 0 actual %h",
                                          pipe_out_valid_o));
        assert (pipe_in_ready_o == 1'b1)
            else report_failure($sformatf("MISMATCH pipe_in_ready_o expected 1 actual %h",
                                          pipe_in_ready_o));
        for (int i = 0; i < NUM_INSTR; i++) begin
            // Back-to-back MUL then ALU pairs first, so the fast unit finishes early
            if (i < DIRECTED_CNT) begin
                unit = (i % 2 == 0) ? UNIT_MUL : UNIT_ALU;
                gap  = 0;
            end else begin
                unit = pick_unit();
                gap  = $urandom_range(0, 3);
            end
            ctrl.unit  = unit;
            ctrl.op    = pick_op(unit);
            ctrl.id    = ID_W'($urandom_range(0, 2**ID_W - 1));
            ctrl.vaddr = VADDR_W'($urandom_range(0, 2**VADDR_W - 1));
            if (gap != 0) begin
                pipe_in_valid_i <= 1'b0;
                repeat (gap) @(posedge clk_i);
            end
            pipe_in_valid_i <= 1'b1;
            pipe_in_ctrl_i  <= ctrl;
            pipe_in_op_a_i  <= pick_operand();
            pipe_in_op_b_i  <= pick_operand();
            do @(posedge clk_i); while (!pipe_in_ready_o);
        end
        pipe_in_valid_i <= 1'b0;
        wait (out_count == NUM_INSTR);
        // Every result is out, so no further output may appear
        repeat (10) begin
            @(posedge clk_i);
            assert (pipe_out_valid_o == 1'b0)
                else report_failure($sformatf("MISMATCH pipe_out_valid_o expected 0 actual %h",
                                              pipe_out_valid_o));
        end
        assert (sb_q.size() == 0)
            else report_failure("Scoreboard still holds results after the run");
        assert (pipe_in_ready_o == 1'b1)
            else report_failure($sformatf("MISMATCH pipe_in_ready_o expected 1 actual %h",
                                          pipe_in_ready_o));
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- test/vunit_mux_props.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the multiplexer output handshake, bound into
// every vunit_mux instance
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_mux_props (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  out_valid_i,
    input  logic                  out_ready_i,
    input  vunit_pkg::pipe_res_t  out_res_i,
    input  logic                  queue_valid_i,
    input  logic [1:0]            unit_valid_i
);

    // A result offered but not taken stays put
    held_output_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_res_i)))
        else $error("Held output changed or dropped before its transfer");

    // Every result waiting in a unit has its order queue entry
    no_output_when_queue_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !queue_valid_i |-> (!out_valid_i && (unit_valid_i == 2'b00)))
        else $error("Output or unit result valid while the order queue is empty");

    valids_low_in_reset: assert property (@(posedge clk_i)
        !arst_n_i |-> (!out_valid_i && !queue_valid_i && (unit_valid_i == 2'b00)))
        else $error("A valid is high while reset is asserted");

endmodule

bind vunit_mux vunit_mux_props u_props (
    .clk_i         ( clk_i            ),
    .arst_n_i      ( arst_n_i         ),
    .out_valid_i   ( pipe_out_valid_o ),
    .out_ready_i   ( pipe_out_ready_i ),
    .out_res_i     ( pipe_out_res_o   ),
    .queue_valid_i ( queue_deq_valid  ),
    .unit_valid_i  ( unit_out_valid   )
);

//--- logic/vunit_mux.sv
////////////////////////////////////////////////////////////////////////////
// Dispatch multiplexer over the ALU and multiply units; the order queue
// keeps results leaving in issue order despite different latencies
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_mux #(
    parameter int unsigned QUEUE_DEPTH = 4,
    parameter int unsigned MUL_STAGES  = 3
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,

    input  logic                         pipe_in_valid_i,
    output logic                         pipe_in_ready_o,
    input  vunit_pkg::pipe_ctrl_t        pipe_in_ctrl_i,
    input  logic [vunit_pkg::DATA_W-1:0] pipe_in_op_a_i,
    input  logic [vunit_pkg::DATA_W-1:0] pipe_in_op_b_i,

    output logic                         pipe_out_valid_o,
    input  logic                         pipe_out_ready_i,
    output vunit_pkg::pipe_res_t         pipe_out_res_o
);

    import vunit_pkg::*;

    localparam int unsigned UNIT_CNT = 2;

    logic [UNIT_CNT-1:0]    unit_in_valid;
    logic [UNIT_CNT-1:0]    unit_in_ready;
    logic [UNIT_CNT-1:0]    unit_out_valid;
    logic [UNIT_CNT-1:0]    unit_out_ready;
    pipe_res_t              unit_out_res [UNIT_CNT];

    logic                   queue_enq_valid;
    logic                   queue_enq_ready;
    logic                   queue_deq_ready;
    logic                   queue_deq_valid;
    op_unit_e               queue_deq_unit;

    // Dispatch: a unit only sees valid when the queue has room, and the
    // queue only sees valid when that unit is ready
    always_comb begin
        unit_in_valid   = '0;
        queue_enq_valid = 1'b0;
        pipe_in_ready_o = queue_enq_ready & unit_in_ready[pipe_in_ctrl_i.unit];
        if (pipe_in_valid_i) begin
            unit_in_valid[pipe_in_ctrl_i.unit] = queue_enq_ready;
            queue_enq_valid                    = unit_in_ready[pipe_in_ctrl_i.unit];
        end
    end

    vunit_order_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH          )
    ) u_order_queue (
        .clk_i       ( clk_i                ),
        .arst_n_i    ( arst_n_i             ),
        .enq_valid_i ( queue_enq_valid      ),
        .enq_ready_o ( queue_enq_ready      ),
        .enq_unit_i  ( pipe_in_ctrl_i.unit  ),
        .deq_ready_i ( queue_deq_ready      ),
        .deq_valid_o ( queue_deq_valid      ),
        .deq_unit_o  ( queue_deq_unit       )
    );

    vunit_alu u_alu (
        .clk_i       ( clk_i                    ),
        .arst_n_i    ( arst_n_i                 ),
        .in_valid_i  ( unit_in_valid[UNIT_ALU]  ),
        .in_ready_o  ( unit_in_ready[UNIT_ALU]  ),
        .in_ctrl_i   ( pipe_in_ctrl_i           ),
        .in_op_a_i   ( pipe_in_op_a_i           ),
        .in_op_b_i   ( pipe_in_op_b_i           ),
        .out_valid_o ( unit_out_valid[UNIT_ALU] ),
        .out_ready_i ( unit_out_ready[UNIT_ALU] ),
        .out_res_o   ( unit_out_res[UNIT_ALU]   )
    );

    vunit_mul #(
        .MUL_STAGES  ( MUL_STAGES               )
    ) u_mul (
        .clk_i       ( clk_i                    ),
        .arst_n_i    ( arst_n_i                 ),
        .in_valid_i  ( unit_in_valid[UNIT_MUL]  ),
        .in_ready_o  ( unit_in_ready[UNIT_MUL]  ),
        .in_ctrl_i   ( pipe_in_ctrl_i           ),
        .in_op_a_i   ( pipe_in_op_a_i           ),
        .in_op_b_i   ( pipe_in_op_b_i           ),
        .out_valid_o ( unit_out_valid[UNIT_MUL] ),
        .out_ready_i ( unit_out_ready[UNIT_MUL] ),
        .out_res_o   ( unit_out_res[UNIT_MUL]   )
    );

    // Output side follows the queue head; the other unit is held off
    always_comb begin
        pipe_out_valid_o = 1'b0;
        pipe_out_res_o   = unit_out_res[UNIT_ALU];
        unit_out_ready   = '0;
        if (queue_deq_valid) begin
            pipe_out_valid_o               = unit_out_valid[queue_deq_unit];
            pipe_out_res_o                 = unit_out_res[queue_deq_unit];
            unit_out_ready[queue_deq_unit] = pipe_out_ready_i;
        end
    end

    // Head entry retires with the output transfer
    assign queue_deq_ready = pipe_out_valid_o & pipe_out_ready_i;

endmodule

//--- logic/vunit_mul.sv
////////////////////////////////////////////////////////////////////////////
// Pipelined unsigned multiply unit, MUL_STAGES deep (at least 2); the
// whole chain freezes while the last stage waits on its consumer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_mul #(
    parameter int unsigned MUL_STAGES = 3
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,

    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vunit_pkg::pipe_ctrl_t        in_ctrl_i,
    input  logic [vunit_pkg::DATA_W-1:0] in_op_a_i,
    input  logic [vunit_pkg::DATA_W-1:0] in_op_b_i,

    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output vunit_pkg::pipe_res_t         out_res_o
);

    import vunit_pkg::*;

    localparam int unsigned LAST = MUL_STAGES - 1;

    logic [MUL_STAGES-1:0]  valid_q;
    pipe_ctrl_t             ctrl_q [MUL_STAGES];
    logic [DATA_W-1:0]      op_a_q;
    logic [DATA_W-1:0]      op_b_q;
    // Stage 0 holds operands, stages 1 and up hold the full product
    logic [2*DATA_W-1:0]    prod_q [1:MUL_STAGES-1];
    logic                   stall;

    assign stall      = valid_q[LAST] & ~out_ready_i;
    assign in_ready_o = ~stall;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (!stall) begin
            valid_q <= {valid_q[MUL_STAGES-2:0], in_valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall) begin
            if (in_valid_i) begin
                op_a_q    <= in_op_a_i;
                op_b_q    <= in_op_b_i;
                ctrl_q[0] <= in_ctrl_i;
            end
            prod_q[1] <= op_a_q * op_b_q;
            ctrl_q[1] <= ctrl_q[0];
            for (int s = 2; s < MUL_STAGES; s++) begin
                prod_q[s] <= prod_q[s-1];
                ctrl_q[s] <= ctrl_q[s-1];
            end
        end
    end

    // Last stage: low or high half of the product
    always_comb begin
        out_res_o.id    = ctrl_q[LAST].id;
        out_res_o.vaddr = ctrl_q[LAST].vaddr;
        if (ctrl_q[LAST].op == OP_MULH) begin
            out_res_o.data = prod_q[LAST][2*DATA_W-1:DATA_W];
        end else begin
            out_res_o.data = prod_q[LAST][DATA_W-1:0];
        end
    end

    assign out_valid_o = valid_q[LAST];

endmodule

//--- logic/vunit_alu.sv
////////////////////////////////////////////////////////////////////////////
// One-stage integer ALU unit; result registered with id and vaddr,
// valid/ready on both sides
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_alu (
    input  logic                         clk_i,
    input  logic                         arst_n_i,

    input  logic                         in_valid_i,
    output logic                         in_ready_o,
    input  vunit_pkg::pipe_ctrl_t        in_ctrl_i,
    input  logic [vunit_pkg::DATA_W-1:0] in_op_a_i,
    input  logic [vunit_pkg::DATA_W-1:0] in_op_b_i,

    output logic                         out_valid_o,
    input  logic                         out_ready_i,
    output vunit_pkg::pipe_res_t         out_res_o
);

    import vunit_pkg::*;

    logic               valid_q;
    pipe_res_t          res_q;
    logic [DATA_W-1:0]  alu_data;
    logic               accept;

    always_comb begin
        case (in_ctrl_i.op)
            OP_ADD:  alu_data = in_op_a_i + in_op_b_i;
            OP_SUB:  alu_data = in_op_a_i - in_op_b_i;
            OP_AND:  alu_data = in_op_a_i & in_op_b_i;
            OP_XOR:  alu_data = in_op_a_i ^ in_op_b_i;
            // Multiply ops never get steered here
            default: alu_data = '0;
        endcase
    end

    // Take new work while the output register is empty or draining
    assign in_ready_o = ~valid_q | out_ready_i;
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q.id    <= in_ctrl_i.id;
            res_q.vaddr <= in_ctrl_i.vaddr;
            res_q.data  <= alu_data;
        end
    end

    assign out_valid_o = valid_q;
    assign out_res_o   = res_q;

endmodule

//--- logic/vunit_order_queue.sv
////////////////////////////////////////////////////////////////////////////
// FIFO of unit tags in issue order; the head tells the output side
// which unit must deliver the next result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vunit_order_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  logic                clk_i,
    input  logic                arst_n_i,

    input  logic                enq_valid_i,
    output logic                enq_ready_o,
    input  vunit_pkg::op_unit_e enq_unit_i,

    input  logic                deq_ready_i,
    output logic                deq_valid_o,
    output vunit_pkg::op_unit_e deq_unit_o
);

    import vunit_pkg::*;

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    op_unit_e           tags_q [QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               full;
    logic               enq_fire;
    logic               deq_fire;

    // Wrap explicitly so that depths other than powers of two work
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full        = (count_q == CNT_W'(QUEUE_DEPTH));
    assign deq_valid_o = (count_q != '0);
    assign deq_unit_o  = tags_q[rd_ptr_q];

    // A full queue still accepts when the head leaves in the same cycle
    assign enq_ready_o = ~full | deq_ready_i;

    assign enq_fire = enq_valid_i & enq_ready_o;
    assign deq_fire = deq_ready_i & deq_valid_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (deq_fire) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({enq_fire, deq_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_fire) begin
            tags_q[wr_ptr_q] <= enq_unit_i;
        end
    end

endmodule

//--- logic/vunit_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, unit and opcode encodings and the pipe structs used
// by the dispatch multiplexer and its execution units
////////////////////////////////////////////////////////////////////////////

package vunit_pkg;

    // Operand and result width
    localparam int unsigned DATA_W  = 32;

    // Instruction id width
    localparam int unsigned ID_W    = 3;

    // Destination vector register address width
    localparam int unsigned VADDR_W = 5;

    // Execution unit selector, also the tag kept in the order queue
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } op_unit_e;

    // MUL and MULH work on the unsigned 64-bit product
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_XOR  = 3'd3,
        OP_MUL  = 3'd4,
        OP_MULH = 3'd5
    } op_code_e;

    // Control word that travels with each instruction
    typedef struct packed {
        op_unit_e             unit;
        op_code_e             op;
        logic [ID_W-1:0]      id;
        logic [VADDR_W-1:0]   vaddr;
    } pipe_ctrl_t;

    // Result as it leaves a unit and the multiplexer
    typedef struct packed {
        logic [ID_W-1:0]      id;
        logic [VADDR_W-1:0]   vaddr;
        logic [DATA_W-1:0]    data;
    } pipe_res_t;

endpackage
